// ==== vlog.f ====
+incdir+include
verilog/iwm_bus_pkg.sv
verilog/iwm_timing_pkg.sv
verilog/iwm_soft_switches.sv
verilog/iwm_active_timer.sv
verilog/drive_spin_model.sv
verilog/sony_head_select.sv
verilog/iwm_register_read.sv
verilog/iwm_woz_top.sv
tb/tb_iwm_woz.sv

// ==== include/iwm_tb_model.svh ====
// Include inside the testbench module; call reset_reference, then advance_reference each edge
`ifndef IWM_TB_MODEL_SVH
`define IWM_TB_MODEL_SVH

// ==================================================
// Model delays, passed to the DUT as well
// ==================================================

localparam int MODEL_ACTIVE_DELAY = 40;
localparam int MODEL_SPINUP       = 30;
localparam int MODEL_SPINDOWN     = 50;

// Expected register state, compared against the DUT outputs
logic [3:0] m_phases;
logic       m_drive_on;
logic       m_drive_sel;
logic       m_q6;
logic       m_q7;
logic [4:0] m_mode;
logic [2:0] m_sense;
logic       m_active;
int         m_delay_cnt;
logic       m_spinning;
int         m_spin_cnt;
logic       m_spun_up;
logic       m_hdsel;
logic [7:0] m_track;

function automatic void reset_reference();
    m_phases    = '0;
    m_drive_on  = 1'b0;
    m_drive_sel = 1'b0;
    m_q6        = 1'b0;
    m_q7        = 1'b0;
    m_mode      = '0;
    m_sense     = '0;
    m_active    = 1'b0;
    m_delay_cnt = 0;
    m_spinning  = 1'b0;
    m_spin_cnt  = 0;
    m_spun_up   = 1'b0;
    m_hdsel     = 1'b0;
    m_track     = '0;
endfunction

// Phases as seen during an access, with the touched switch already applied
function automatic logic [3:0] apply_phase_touch(logic acc, logic [3:0] a);
    logic [3:0] p;
    p = m_phases;
    if (acc && (a[3:1] < 3'd4)) begin
        p[a[2:1]] = a[0];
    end
    return p;
endfunction

function automatic logic [2:0] predict_sense_sel(logic ph2, logic dsel, logic [3:0] a);
    logic [3:0] p;
    p = apply_phase_touch(ph2 && dsel, a);
    return (ph2 && dsel && (a[3:1] < 3'd4)) ? p[2:0] : m_sense;
endfunction

// Expected D_OUT for the current cycle's bus inputs
function automatic logic [7:0] compute_expected_dout(logic ph2, logic dsel, logic wr_cycle,
                                                     logic [3:0] a, logic [7:0] d_in,
                                                     logic [3:0] ready, logic [7:0] disk35,
                                                     logic sense);
    logic       acc;
    logic       q6n;
    logic       q7n;
    logic [4:0] moden;
    logic       present;
    logic       force_rd;
    acc      = ph2 && dsel;
    q6n      = (acc && (a[3:1] == 3'd6)) ? a[0] : m_q6;
    q7n      = (acc && (a[3:1] == 3'd7)) ? a[0] : m_q7;
    moden    = (acc && !wr_cycle && !m_active && (a == 4'hF)) ? d_in[4:0] : m_mode;
    present  = disk35[6] ? ready[{1'b1, m_drive_sel}] : ready[{1'b0, m_drive_sel}];
    force_rd = acc && wr_cycle && (a == 4'hC) && m_drive_on && present
               && !(moden[1] && !moden[3]);
    if (force_rd) begin
        q7n = 1'b0;
    end
    if (q6n && !q7n) begin
        return {(m_drive_on ? sense : 1'b1), 1'b0, m_active, moden};
    end
    return (q7n && !q6n) ? 8'h80 : 8'hFF;
endfunction

// Advances every register by one clock edge from the old state
function automatic void advance_reference(logic ph2, logic dsel, logic wr_cycle,
                                          logic [3:0] a, logic [7:0] d_in,
                                          logic [7:0] disk35, logic [6:0] cyl);
    logic acc;
    logic mode_wr;
    logic imm_off;
    logic hd;
    acc     = ph2 && dsel;
    mode_wr = acc && !wr_cycle && !m_active && (a == 4'hF);
    imm_off = mode_wr ? d_in[2] : m_mode[2];
    // Active timer
    if (acc && (a[3:1] == 3'd4) && a[0] && !m_drive_on) begin
        m_active    = 1'b1;
        m_delay_cnt = MODEL_ACTIVE_DELAY;
    end else if (acc && (a[3:1] == 3'd4) && !a[0] && m_drive_on) begin
        m_active    = !imm_off;
        m_delay_cnt = imm_off ? 0 : MODEL_ACTIVE_DELAY;
    end else if (m_drive_on) begin
        m_active    = 1'b1;
        m_delay_cnt = MODEL_ACTIVE_DELAY;
    end else if (m_active) begin
        if (m_delay_cnt != 0) m_delay_cnt--;
        else m_active = 1'b0;
    end
    // Spindle inertia
    if (m_drive_on && disk35[6]) begin
        m_spinning = 1'b0;
    end else if (m_drive_on && !m_spun_up) begin
        if (m_spin_cnt >= MODEL_SPINUP) begin
            m_spinning = 1'b1;
            m_spun_up  = 1'b1;
            m_spin_cnt = MODEL_SPINDOWN;
        end else begin
            m_spin_cnt++;
        end
    end else if (m_drive_on) begin
        m_spinning = 1'b1;
        m_spin_cnt = MODEL_SPINDOWN;
    end else begin
        m_spun_up = 1'b0;
        if (m_spin_cnt != 0) m_spin_cnt--;
        else m_spinning = 1'b0;
    end
    // Head select and track
    hd      = disk35[6] ? disk35[7] : m_hdsel;
    m_track = {cyl, hd};
    if (disk35[6]) m_hdsel = disk35[7];
    // Switches last, so the blocks above saw the old values
    if (acc && (a[3:1] < 3'd4)) begin
        m_phases = apply_phase_touch(acc, a);
        m_sense  = m_phases[2:0];
    end
    if (acc && (a[3:1] == 3'd4)) m_drive_on = a[0];
    if (acc && (a[3:1] == 3'd5)) m_drive_sel = a[0];
    if (acc && (a[3:1] == 3'd6)) m_q6 = a[0];
    if (acc && (a[3:1] == 3'd7)) m_q7 = a[0];
    if (mode_wr) m_mode = d_in[4:0];
endfunction

`endif

// ==== tb/tb_iwm_woz.sv ====
// Random bus traffic from a fixed seed; short delays (40/30/50) stand in for the real timings
`timescale 1ns/100ps

module tb_iwm_woz;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_CYCLES = 4000;

    logic       CLK_14M;
    logic       RESET;
    logic       PH2;
    logic       DEVICE_SELECT;
    logic       WR_CYCLE;
    logic [3:0] A;
    logic [7:0] D_IN;
    logic [3:0] DISK_READY;
    logic [7:0] DISK35;
    logic       SENSE;
    logic [6:0] CYLINDER35;
    logic [7:0] D_OUT;
    logic [3:0] PHASES;
    logic       DRIVE_ON;
    logic       DRIVE_SEL;
    logic [2:0] SENSE_SEL;
    logic [7:0] WOZ_TRACK3;
    logic       FLOPPY_MOTOR_ON;

    int   seed = 32'hf0b5;
    int   errors = 0;
    int   checks = 0;
    logic sel35_next;

    `include "iwm_tb_model.svh"

    iwm_woz_top #(
        .ACTIVE_DELAY(MODEL_ACTIVE_DELAY),
        .SPINUP(MODEL_SPINUP),
        .SPINDOWN(MODEL_SPINDOWN)
    ) uut (
        .CLK_14M(CLK_14M), .RESET(RESET), .PH2(PH2), .DEVICE_SELECT(DEVICE_SELECT),
        .WR_CYCLE(WR_CYCLE), .A(A), .D_IN(D_IN), .DISK_READY(DISK_READY),
        .DISK35(DISK35), .SENSE(SENSE), .CYLINDER35(CYLINDER35), .D_OUT(D_OUT),
        .PHASES(PHASES), .DRIVE_ON(DRIVE_ON), .DRIVE_SEL(DRIVE_SEL),
        .SENSE_SEL(SENSE_SEL), .WOZ_TRACK3(WOZ_TRACK3), .FLOPPY_MOTOR_ON(FLOPPY_MOTOR_ON)
    );

    // ==================================================
    // Clock and watchdog
    // ==================================================

    initial begin
        CLK_14M = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;
    end

    // The 100 spare cycles cover reset and the final check
    initial begin
        #((NUM_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog expired before the random run completed");
        $display("Done: errors found");
        $finish;
    end

    // ==================================================
    // Helpers
    // ==================================================

    task automatic report_mismatch(string name, logic [7:0] got, logic [7:0] exp);
        errors++;
        $display("[FAIL] %0t %s got 0x%h expected 0x%h", $time, name, got, exp);
    endtask

    // New bus cycle on every rising edge
    task automatic drive_random_inputs();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        // The 3.5" select flips rarely, so the 5.25" spindle gets time to spin up
        if (r2[3:0] == 4'h0) begin
            sel35_next = ~sel35_next;
        end
        PH2           <= r1[0];
        DEVICE_SELECT <= r1[1];
        WR_CYCLE      <= r1[2];
        A             <= r1[6:3];
        D_IN          <= r1[14:7];
        SENSE         <= r1[15];
        DISK_READY    <= r1[19:16];
        CYLINDER35    <= r1[26:20];
        DISK35        <= {r2[4], sel35_next, r2[10:5]};
    endtask

    // Sampled on the falling edge, well away from the input updates
    task automatic check_outputs();
        logic [7:0] exp_dout;
        logic [2:0] exp_sense;
        exp_dout  = compute_expected_dout(PH2, DEVICE_SELECT, WR_CYCLE, A, D_IN, DISK_READY,
                                          DISK35, SENSE);
        exp_sense = predict_sense_sel(PH2, DEVICE_SELECT, A);
        checks++;
        if (PHASES !== m_phases) report_mismatch("PHASES", {4'h0, PHASES}, {4'h0, m_phases});
        if (DRIVE_ON !== m_drive_on) report_mismatch("DRIVE_ON", {7'h0, DRIVE_ON},
                                                     {7'h0, m_drive_on});
        if (DRIVE_SEL !== m_drive_sel) report_mismatch("DRIVE_SEL", {7'h0, DRIVE_SEL},
                                                       {7'h0, m_drive_sel});
        if (SENSE_SEL !== exp_sense) report_mismatch("SENSE_SEL", {5'h0, SENSE_SEL},
                                                     {5'h0, exp_sense});
        // Status, handshake and forced data reads all land on D_OUT
        if (D_OUT !== exp_dout) report_mismatch("D_OUT", D_OUT, exp_dout);
        if (WOZ_TRACK3 !== m_track) report_mismatch("WOZ_TRACK3", WOZ_TRACK3, m_track);
        if (FLOPPY_MOTOR_ON !== m_spinning) report_mismatch("FLOPPY_MOTOR_ON",
                                                            {7'h0, FLOPPY_MOTOR_ON},
                                                            {7'h0, m_spinning});
    endtask

    // ==================================================
    // Stimulus and checking
    // ==================================================

    initial begin
        RESET         = 1'b1;
        PH2           = 1'b0;
        DEVICE_SELECT = 1'b0;
        WR_CYCLE      = 1'b1;
        A             = '0;
        D_IN          = '0;
        DISK_READY    = '0;
        DISK35        = '0;
        SENSE         = 1'b0;
        CYLINDER35    = '0;
        sel35_next    = 1'b0;
        reset_reference();
        repeat (5) @(posedge CLK_14M);
        RESET <= 1'b0;
        drive_random_inputs();
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(negedge CLK_14M);
            check_outputs();
            // The model steps on the inputs the DUT saw at this edge
            @(posedge CLK_14M);
            advance_reference(PH2, DEVICE_SELECT, WR_CYCLE, A, D_IN, DISK35, CYLINDER35);
            drive_random_inputs();
        end
        @(negedge CLK_14M);
        check_outputs();
        $display("Summary: %0d cycles checked, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/iwm_woz_top.sv ====
// Drives live outside; they take PHASES, DRIVE_ON, DRIVE_SEL, SENSE_SEL and return SENSE
`timescale 1ns/100ps

module iwm_woz_top
    import iwm_bus_pkg::*;
    import iwm_timing_pkg::*;
#(
    parameter int ACTIVE_DELAY = ACTIVE_DELAY_DEFAULT,
    parameter int SPINUP       = SPINUP_DEFAULT,
    parameter int SPINDOWN     = SPINDOWN_DEFAULT
) (
    input  logic                 CLK_14M,
    input  logic                 RESET,
    input  logic                 PH2,
    input  logic                 DEVICE_SELECT,
    input  logic                 WR_CYCLE,
    input  logic [SW_ADDR_W-1:0] A,
    input  logic [7:0]           D_IN,
    input  logic [3:0]           DISK_READY,
    input  logic [7:0]           DISK35,
    input  logic                 SENSE,
    input  logic [6:0]           CYLINDER35,
    output logic [7:0]           D_OUT,
    output logic [3:0]           PHASES,
    output logic                 DRIVE_ON,
    output logic                 DRIVE_SEL,
    output logic [2:0]           SENSE_SEL,
    output logic [7:0]           WOZ_TRACK3,
    output logic                 FLOPPY_MOTOR_ON
);

    logic                 q6_now;
    logic                 q7_now;
    logic [MODE_W-1:0]    mode_now;
    logic                 rd_strobe;
    logic [SW_ADDR_W-1:0] rd_addr;
    logic                 motor_access;
    logic                 motor_new;
    logic                 iwm_active;
    logic                 sel35;

    // Drive type comes from the 3.5" select in DISK35 alone
    assign sel35 = DISK35[DISKREG_SEL35_BIT];

    iwm_soft_switches u_switches (
        .CLK_14M(CLK_14M), .RESET(RESET), .PH2(PH2), .DEVICE_SELECT(DEVICE_SELECT),
        .WR_CYCLE(WR_CYCLE), .A(A), .D_IN(D_IN), .iwm_active(iwm_active),
        .phases(PHASES), .drive_on(DRIVE_ON), .drive_sel(DRIVE_SEL),
        .q6_now(q6_now), .q7_now(q7_now), .mode_now(mode_now), .sense_sel(SENSE_SEL),
        .rd_strobe(rd_strobe), .rd_addr(rd_addr),
        .motor_access(motor_access), .motor_new(motor_new)
    );

    iwm_active_timer #(.ACTIVE_DELAY(ACTIVE_DELAY)) u_active (
        .CLK_14M(CLK_14M), .RESET(RESET), .motor_access(motor_access),
        .motor_new(motor_new), .drive_on(DRIVE_ON),
        .immediate_off(mode_now[MODE_IMMEDIATE_OFF_BIT]), .iwm_active(iwm_active)
    );

    drive_spin_model #(.SPINUP(SPINUP), .SPINDOWN(SPINDOWN)) u_spin (
        .CLK_14M(CLK_14M), .RESET(RESET), .drive_on(DRIVE_ON), .sel35(sel35),
        .spinning(FLOPPY_MOTOR_ON)
    );

    sony_head_select u_head (
        .CLK_14M(CLK_14M), .RESET(RESET), .DISK35(DISK35), .CYLINDER35(CYLINDER35),
        .WOZ_TRACK3(WOZ_TRACK3)
    );

    iwm_register_read u_read (
        .rd_strobe(rd_strobe), .rd_addr(rd_addr), .q6_now(q6_now), .q7_now(q7_now),
        .mode_now(mode_now), .iwm_active(iwm_active), .drive_on(DRIVE_ON),
        .drive_sel(DRIVE_SEL), .sel35(sel35), .DISK_READY(DISK_READY), .SENSE(SENSE),
        .D_OUT(D_OUT)
    );

endmodule

// ==== verilog/iwm_register_read.sv ====
// Data register has no decoder and reads all ones; output is purely combinational
`timescale 1ns/100ps

module iwm_register_read
    import iwm_bus_pkg::*;
(
    input  logic                 rd_strobe,
    input  logic [SW_ADDR_W-1:0] rd_addr,
    input  logic                 q6_now,
    input  logic                 q7_now,
    input  logic [MODE_W-1:0]    mode_now,
    input  logic                 iwm_active,
    input  logic                 drive_on,
    input  logic                 drive_sel,
    input  logic                 sel35,
    input  logic [3:0]           DISK_READY,
    input  logic                 SENSE,
    output logic [7:0]           D_OUT
);

    logic       disk_present;
    logic       smartport;
    logic       force_data;
    logic       q7_eff;
    logic [7:0] status;

    // Drives 2 and 3 are the 3.5" pair, 0 and 1 the 5.25" pair
    assign disk_present = sel35 ? (drive_sel ? DISK_READY[3] : DISK_READY[2])
                                : (drive_sel ? DISK_READY[1] : DISK_READY[0]);

    // SmartPort polls offset C as handshake, so the forced data read stays off there
    assign smartport  = mode_now[MODE_SMARTPORT_BIT] && !mode_now[MODE_FAST_BIT];
    assign force_data = rd_strobe && (rd_addr == ADDR_DATA) && drive_on
                        && !smartport && disk_present;
    assign q7_eff     = force_data ? 1'b0 : q7_now;

    // Sense floats high with no drive enabled
    always_comb begin
        status                    = '0;
        status[STATUS_SENSE_BIT]  = drive_on ? SENSE : 1'b1;
        status[STATUS_ACTIVE_BIT] = iwm_active;
        status[MODE_W-1:0]        = mode_now;
    end

    always_comb begin
        case ({q7_eff, q6_now})
            2'b01:   D_OUT = status;
            2'b10:   D_OUT = RD_HANDSHAKE;
            default: D_OUT = RD_IDLE;
        endcase
    end

endmodule

// ==== verilog/sony_head_select.sv ====
// Track number is cylinder*2 + side; HDSEL only updates while the 3.5" select is set
`timescale 1ns/100ps

module sony_head_select
    import iwm_bus_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic [7:0] DISK35,
    input  logic [6:0] CYLINDER35,
    output logic [7:0] WOZ_TRACK3
);

    logic sel35;
    logic hdsel_latched;
    logic hdsel;

    assign sel35 = DISK35[DISKREG_SEL35_BIT];

    // Live HDSEL while selected, otherwise the copy from the last selected cycle.
    // This rides out short deselect windows between Sony commands
    assign hdsel = sel35 ? DISK35[DISKREG_HDSEL_BIT] : hdsel_latched;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            hdsel_latched <= 1'b0;
            WOZ_TRACK3    <= '0;
        end else begin
            if (sel35) begin
                hdsel_latched <= DISK35[DISKREG_HDSEL_BIT];
            end
            // Side sits in the low bit, one cycle behind the inputs
            WOZ_TRACK3 <= {CYLINDER35, hdsel};
        end
    end

endmodule

// ==== verilog/drive_spin_model.sv ====
// Models 5.25" inertia only; a 3.5" select forces spinning low while the motor is on
`timescale 1ns/100ps

module drive_spin_model
    import iwm_timing_pkg::*;
#(
    parameter int SPINUP   = SPINUP_DEFAULT,
    parameter int SPINDOWN = SPINDOWN_DEFAULT
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic drive_on,
    input  logic sel35,
    output logic spinning
);

    logic [DELAY_W-1:0] spin_cnt;
    logic               spun_up;

    // ==================================================
    // Spindle counter
    // ==================================================

    // One counter serves both directions.
    // It climbs toward SPINUP while on, then parks at SPINDOWN and counts down after motor off
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            spinning <= 1'b0;
            spin_cnt <= '0;
            spun_up  <= 1'b0;
        end else if (drive_on) begin
            if (sel35) begin
                // Sony drives spin themselves, so the 5.25" model stays quiet
                spinning <= 1'b0;
            end else if (!spun_up) begin
                if (spin_cnt >= DELAY_W'(SPINUP)) begin
                    spinning <= 1'b1;
                    spun_up  <= 1'b1;
                    spin_cnt <= DELAY_W'(SPINDOWN);
                end else begin
                    spin_cnt <= spin_cnt + 1'b1;
                end
            end else begin
                spinning <= 1'b1;
                spin_cnt <= DELAY_W'(SPINDOWN);
            end
        end else begin
            // Motor off, so the spindle coasts until the counter empties
            spun_up <= 1'b0;
            if (spin_cnt != '0) begin
                spin_cnt <= spin_cnt - 1'b1;
            end else begin
                spinning <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/iwm_active_timer.sv ====
// ACTIVE_DELAY must fit in DELAY_W bits; drive_on must be the switch value before the access
`timescale 1ns/100ps

module iwm_active_timer
    import iwm_timing_pkg::*;
#(
    parameter int ACTIVE_DELAY = ACTIVE_DELAY_DEFAULT
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic motor_access,
    input  logic motor_new,
    input  logic drive_on,
    input  logic immediate_off,
    output logic iwm_active
);

    logic               on_edge;
    logic               off_edge;
    logic [DELAY_W-1:0] delay_cnt;

    // Only real transitions count, so repeated off accesses keep the countdown running
    assign on_edge  = motor_access && motor_new && !drive_on;
    assign off_edge = motor_access && !motor_new && drive_on;

    // ==================================================
    // Active state and delayed-off counter
    // ==================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            iwm_active <= 1'b0;
            delay_cnt  <= '0;
        end else if (on_edge) begin
            iwm_active <= 1'b1;
            delay_cnt  <= DELAY_W'(ACTIVE_DELAY);
        end else if (off_edge) begin
            // Mode bit 2 drops active at once, otherwise the delay starts now
            if (immediate_off) begin
                iwm_active <= 1'b0;
                delay_cnt  <= '0;
            end else begin
                iwm_active <= 1'b1;
                delay_cnt  <= DELAY_W'(ACTIVE_DELAY);
            end
        end else if (drive_on) begin
            // Held reloaded while the motor is commanded on
            iwm_active <= 1'b1;
            delay_cnt  <= DELAY_W'(ACTIVE_DELAY);
        end else if (iwm_active) begin
            if (delay_cnt != '0) begin
                delay_cnt <= delay_cnt - 1'b1;
            end else begin
                // Falls one cycle after the count reaches zero
                iwm_active <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/iwm_soft_switches.sv ====
// Bus inputs must be stable while PH2 and DEVICE_SELECT are high; one access per strobe
`timescale 1ns/100ps

module iwm_soft_switches
    import iwm_bus_pkg::*;
(
    input  logic                 CLK_14M,
    input  logic                 RESET,
    input  logic                 PH2,
    input  logic                 DEVICE_SELECT,
    input  logic                 WR_CYCLE,
    input  logic [SW_ADDR_W-1:0] A,
    input  logic [7:0]           D_IN,
    input  logic                 iwm_active,
    output logic [3:0]           phases,
    output logic                 drive_on,
    output logic                 drive_sel,
    output logic                 q6_now,
    output logic                 q7_now,
    output logic [MODE_W-1:0]    mode_now,
    output logic [2:0]           sense_sel,
    output logic                 rd_strobe,
    output logic [SW_ADDR_W-1:0] rd_addr,
    output logic                 motor_access,
    output logic                 motor_new
);

    logic              access;
    logic              wr_strobe;
    logic [2:0]        sw;
    logic              phase_access;
    logic              mode_write;
    logic [3:0]        phases_now;
    logic              q6;
    logic              q7;
    logic [MODE_W-1:0] mode_reg;
    logic [2:0]        sense_reg;

    // ==================================================
    // Bus decode
    // ==================================================

    // Every PH2 cycle with the device selected is one access, read or write
    assign access    = PH2 && DEVICE_SELECT;
    assign rd_strobe = access && WR_CYCLE;
    assign wr_strobe = access && !WR_CYCLE;
    assign rd_addr   = A;
    assign sw        = A[3:1];

    // Phase switches occupy the four lowest groups
    assign phase_access = access && (sw <= SW_PHASE3);

    // The mode register only takes writes while the IWM is idle
    assign mode_write = wr_strobe && !iwm_active && (A == ADDR_MODE);

    assign motor_access = access && (sw == SW_MOTOR);
    assign motor_new    = A[0];

    // ==================================================
    // Same-cycle views
    // ==================================================

    // Phase group codes map straight onto phase bit indices
    always_comb begin
        phases_now = phases;
        if (phase_access) begin
            phases_now[sw[1:0]] = A[0];
        end
    end

    // Reads in the access cycle must see the value this access sets
    assign q6_now    = (access && (sw == SW_Q6)) ? A[0] : q6;
    assign q7_now    = (access && (sw == SW_Q7)) ? A[0] : q7;
    assign mode_now  = mode_write ? D_IN[MODE_W-1:0] : mode_reg;
    assign sense_sel = phase_access ? phases_now[2:0] : sense_reg;

    // ==================================================
    // Switch registers
    // ==================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            phases    <= '0;
            drive_on  <= 1'b0;
            drive_sel <= 1'b0;
            q6        <= 1'b0;
            q7        <= 1'b0;
            mode_reg  <= '0;
            sense_reg <= '0;
        end else begin
            // Touch switches change on any access, reads included
            if (access) begin
                case (sw)
                    SW_PHASE0, SW_PHASE1, SW_PHASE2, SW_PHASE3: phases <= phases_now;
                    SW_MOTOR: drive_on  <= A[0];
                    SW_DRIVE: drive_sel <= A[0];
                    SW_Q6:    q6        <= A[0];
                    SW_Q7:    q7        <= A[0];
                endcase
            end
            // The sense index follows every phase access, set or clear
            if (phase_access) begin
                sense_reg <= phases_now[2:0];
            end
            if (mode_write) begin
                mode_reg <= D_IN[MODE_W-1:0];
            end
        end
    end

endmodule

// ==== verilog/iwm_timing_pkg.sv ====
// Delay defaults assume a 14 MHz clock; every count must fit in DELAY_W bits
package iwm_timing_pkg;

    // ==================================================
    // Counter sizing
    // ==================================================

    // 24 bits holds a little over one second of 14 MHz cycles
    localparam int DELAY_W = 24;

    // ==================================================
    // Default delays in clock cycles
    // ==================================================

    // Delayed motor-off of the IWM active state, about one second
    localparam int ACTIVE_DELAY_DEFAULT = 14000000;

    // 5.25" spindle spin-up, about 300 ms
    localparam int SPINUP_DEFAULT = 4200000;

    // 5.25" spindle coast after motor off, about one second
    localparam int SPINDOWN_DEFAULT = 14000000;

endpackage

// ==== verilog/iwm_bus_pkg.sv ====
// Bus decode constants for the IWM soft switches; only A[3:0] of the IWM page is decoded
package iwm_bus_pkg;

    // ==================================================
    // Address fields
    // ==================================================

    // Width of the switch offset within the IWM page
    localparam int SW_ADDR_W = 4;

    // Touch switch groups selected by A[3:1], with A[0] carrying the new value
    localparam logic [2:0] SW_PHASE0 = 3'd0;
    localparam logic [2:0] SW_PHASE1 = 3'd1;
    localparam logic [2:0] SW_PHASE2 = 3'd2;
    localparam logic [2:0] SW_PHASE3 = 3'd3;
    localparam logic [2:0] SW_MOTOR  = 3'd4;
    localparam logic [2:0] SW_DRIVE  = 3'd5;
    localparam logic [2:0] SW_Q6     = 3'd6;
    localparam logic [2:0] SW_Q7     = 3'd7;

    // Mode register writes land on offset F, forced data reads on offset C
    localparam logic [SW_ADDR_W-1:0] ADDR_MODE = 4'hF;
    localparam logic [SW_ADDR_W-1:0] ADDR_DATA = 4'hC;

    // ==================================================
    // Mode and read encodings
    // ==================================================

    localparam int MODE_W                 = 5;
    localparam int MODE_IMMEDIATE_OFF_BIT = 2;
    // SmartPort mode is bit 1 set with bit 3 clear
    localparam int MODE_SMARTPORT_BIT     = 1;
    localparam int MODE_FAST_BIT          = 3;

    localparam logic [7:0] RD_HANDSHAKE = 8'h80;
    localparam logic [7:0] RD_IDLE      = 8'hFF;
    localparam int STATUS_SENSE_BIT     = 7;
    localparam int STATUS_ACTIVE_BIT    = 5;

    // Fields of the DISK35 register
    localparam int DISKREG_SEL35_BIT = 6;
    localparam int DISKREG_HDSEL_BIT = 7;

endpackage
